// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int ISA_WIDTH      = 32;
    localparam int FUNCT7_WIDTH   = 7;
    localparam int INST_NUM_WIDTH = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded instruction numbers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [INST_NUM_WIDTH-1:0] {
        inv,
        add,
        sub,
        srl,
        sra,
        addi,
        srli,
        srai,
        ebreak
    } inst_num_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word views.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [FUNCT7_WIDTH-1:0] funct7;
        logic [4:0]              rs2;
        logic [4:0]              rs1;
        logic [2:0]              funct3;
        logic [4:0]              rd;
        logic [6:0]              opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Same 32 bits, read as R-type or I-type.
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_word_u;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_SR  = 3'b101; // srl/sra and srli/srai.

    localparam logic [ISA_WIDTH-1:0] EBREAK_WORD = 32'h0010_0073;

endpackage

`default_nettype wire

// File: hdl/imem_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface imem_bus_if #(
    parameter int ADDR_WIDTH = 6
);
    import rv_pkg::*;

    logic                  req;
    logic [ADDR_WIDTH-1:0] addr;  // Word address.
    logic                  gnt;
    inst_word_u            rdata; // Valid the cycle after the grant.

    modport requester (output req, output addr, input gnt, input rdata);
    modport arbiter (input req, input addr, output gnt, output rdata);

endinterface

`default_nettype wire

// File: hdl/inst_mem.sv
`timescale 1ns/1ns
`default_nettype none

module inst_mem #(
    parameter int ADDR_WIDTH = 6
) (
    input  wire logic                           clk,
    input  wire logic [ADDR_WIDTH-1:0]          rd_addr,
    output rv_pkg::inst_word_u                  rd_data,
    input  wire logic                           load_en,
    input  wire logic [ADDR_WIDTH-1:0]          load_addr,
    input  wire logic [rv_pkg::ISA_WIDTH-1:0]   load_data
);
    import rv_pkg::*;

    logic [ISA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Load port.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr]; // One-cycle read.
    end

endmodule

`default_nettype wire

// File: hdl/imem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module imem_arbiter #(
    parameter int ADDR_WIDTH = 6
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    imem_bus_if.arbiter               port0,
    imem_bus_if.arbiter               port1,
    output logic [ADDR_WIDTH-1:0]     mem_addr,
    input  wire rv_pkg::inst_word_u   mem_rdata
);

    logic last_gnt1; // Port 1 won the last grant.
    logic gnt0;
    logic gnt1;

    // Round robin. The port not granted last time wins a tie.
    always_comb begin
        gnt0 = port0.req && (!port1.req || last_gnt1);
        gnt1 = port1.req && (!port0.req || !last_gnt1);
    end

    assign port0.gnt = gnt0;
    assign port1.gnt = gnt1;

    assign mem_addr    = gnt1 ? port1.addr : port0.addr;
    assign port0.rdata = mem_rdata;
    assign port1.rdata = mem_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_gnt1 <= 1'b1; // Port 0 first.
        end else if (gnt0 || gnt1) begin
            last_gnt1 <= gnt1;
        end
    end

    // A port that loses a tie is granted in the next cycle.
    a_rr_port0: assert property (@(posedge clk) disable iff (!rst_n)
        port0.req && !port0.gnt |=> port0.gnt);

    a_rr_port1: assert property (@(posedge clk) disable iff (!rst_n)
        port1.req && !port1.gnt |=> port1.gnt);

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter int ADDR_WIDTH = 6,
    parameter int START_PC   = 0
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               run,
    imem_bus_if.requester           bus,
    output logic                    valid,
    output logic [ADDR_WIDTH+1:0]   pc,
    output rv_pkg::inst_word_u      inst
);

    localparam logic [ADDR_WIDTH+1:0] RESET_PC = START_PC[ADDR_WIDTH+1:0];

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_GNT,
        ST_WAIT_DATA
    } state_e;

    state_e                state;
    state_e                state_nxt;
    logic [ADDR_WIDTH+1:0] fetch_pc; // Byte address being fetched.

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:      if (run) state_nxt = ST_WAIT_GNT;
            ST_WAIT_GNT:  if (bus.gnt) state_nxt = ST_WAIT_DATA;
            ST_WAIT_DATA: state_nxt = run ? ST_WAIT_GNT : ST_IDLE;
            default:      state_nxt = ST_IDLE;
        endcase
    end

    assign bus.req  = (state == ST_WAIT_GNT);
    assign bus.addr = fetch_pc[ADDR_WIDTH+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            fetch_pc <= RESET_PC;
            pc       <= RESET_PC;
            valid    <= 1'b0;
        end else begin
            state <= state_nxt;
            valid <= (state == ST_WAIT_DATA);
            if (state == ST_WAIT_DATA) begin
                pc       <= fetch_pc;
                fetch_pc <= fetch_pc + 'd4; // Wraps with the memory.
            end
        end
    end

    // Word capture.
    always_ff @(posedge clk) begin
        if (state == ST_WAIT_DATA) begin
            inst <= bus.rdata;
        end
    end

    a_hold_addr: assert property (@(posedge clk) disable iff (!rst_n)
        bus.req && !bus.gnt |=> bus.req && $stable(bus.addr));

endmodule

`default_nettype wire

// File: hdl/idu_funct7.sv
`timescale 1ns/1ns
`default_nettype none

module idu_funct7 (
    input  wire rv_pkg::inst_word_u inst,
    output rv_pkg::inst_num_e       shift_imm_num,
    output rv_pkg::inst_num_e       add_num,
    output rv_pkg::inst_num_e       shift_reg_num,
    output rv_pkg::inst_num_e       ebreak_num
);
    import rv_pkg::*;

    localparam logic [FUNCT7_WIDTH-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_WIDTH-1:0] F7_ALT  = 7'b0100000;

    // Two-entry table keyed by funct7, inv on a miss.
    function automatic inst_num_e f7_pick(
        input logic [FUNCT7_WIDTH-1:0] funct7,
        input inst_num_e               base_num,
        input inst_num_e               alt_num
    );
        case (funct7)
            F7_BASE: f7_pick = base_num;
            F7_ALT:  f7_pick = alt_num;
            default: f7_pick = inv;
        endcase
    endfunction

    always_comb begin
        shift_imm_num = f7_pick(inst.r.funct7, srli, srai);
        add_num       = f7_pick(inst.r.funct7, add, sub);
        shift_reg_num = f7_pick(inst.r.funct7, srl, sra);
        ebreak_num    = (inst == EBREAK_WORD) ? ebreak : inv; // Whole word.
    end

endmodule

`default_nettype wire

// File: hdl/idu.sv
`timescale 1ns/1ns
`default_nettype none

module idu (
    input  wire rv_pkg::inst_word_u inst,
    output rv_pkg::inst_num_e       inst_num,
    output logic [4:0]              rs2,
    output logic [11:0]             imm
);
    import rv_pkg::*;

    inst_num_e shift_imm_num;
    inst_num_e add_num;
    inst_num_e shift_reg_num;
    inst_num_e ebreak_num;

    idu_funct7 u_funct7 (
        .inst          (inst),
        .shift_imm_num (shift_imm_num),
        .add_num       (add_num),
        .shift_reg_num (shift_reg_num),
        .ebreak_num    (ebreak_num)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode and funct3 select.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case ({inst.r.opcode, inst.r.funct3})
            {OPCODE_OP, FUNCT3_ADD}:     inst_num = add_num;
            {OPCODE_OP, FUNCT3_SR}:      inst_num = shift_reg_num;
            {OPCODE_OP_IMM, FUNCT3_ADD}: inst_num = addi;
            {OPCODE_OP_IMM, FUNCT3_SR}:  inst_num = shift_imm_num;
            default:                     inst_num = ebreak_num;
        endcase
    end

    // Operand fields only for the formats that carry them.
    always_comb begin
        rs2 = '0;
        imm = '0;
        if (inst_num inside {add, sub, srl, sra}) begin
            rs2 = inst.r.rs2;
        end
        if (inst_num inside {addi, srli, srai}) begin
            imm = inst.i.imm;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_frontend_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_frontend_top #(
    parameter int ADDR_WIDTH = 6
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         run,
    input  wire logic                         load_en,
    input  wire logic [ADDR_WIDTH-1:0]        load_addr,
    input  wire logic [rv_pkg::ISA_WIDTH-1:0] load_data,
    output logic                              h0_valid,
    output logic [ADDR_WIDTH+1:0]             h0_pc,
    output rv_pkg::inst_num_e                 h0_inst_num,
    output logic [4:0]                        h0_rs2,
    output logic [11:0]                       h0_imm,
    output logic                              h1_valid,
    output logic [ADDR_WIDTH+1:0]             h1_pc,
    output rv_pkg::inst_num_e                 h1_inst_num,
    output logic [4:0]                        h1_rs2,
    output logic [11:0]                       h1_imm
);
    import rv_pkg::*;

    localparam int H0_START_PC = 0;
    localparam int H1_START_PC = 128; // Upper half of a 64-word memory.

    logic [ADDR_WIDTH-1:0] mem_addr;
    inst_word_u            mem_rdata;
    inst_word_u            h0_inst;
    inst_word_u            h1_inst;

    imem_bus_if #(.ADDR_WIDTH(ADDR_WIDTH)) bus0 ();
    imem_bus_if #(.ADDR_WIDTH(ADDR_WIDTH)) bus1 ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Hart 0 lane.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fetch_unit #(.ADDR_WIDTH(ADDR_WIDTH), .START_PC(H0_START_PC)) u_fetch0 (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .bus   (bus0.requester),
        .valid (h0_valid),
        .pc    (h0_pc),
        .inst  (h0_inst)
    );

    idu u_idu0 (.inst(h0_inst), .inst_num(h0_inst_num), .rs2(h0_rs2), .imm(h0_imm));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Hart 1 lane.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fetch_unit #(.ADDR_WIDTH(ADDR_WIDTH), .START_PC(H1_START_PC)) u_fetch1 (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .bus   (bus1.requester),
        .valid (h1_valid),
        .pc    (h1_pc),
        .inst  (h1_inst)
    );

    idu u_idu1 (.inst(h1_inst), .inst_num(h1_inst_num), .rs2(h1_rs2), .imm(h1_imm));

    // Shared memory.
    imem_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .port0     (bus0.arbiter),
        .port1     (bus1.arbiter),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata)
    );

    inst_mem #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem (
        .clk       (clk),
        .rd_addr   (mem_addr),
        .rd_data   (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

// File: testbench/tb_rv_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_frontend;
    import rv_pkg::*;

    localparam int ADDR_WIDTH = 6;
    localparam int WORDS      = 2**ADDR_WIDTH;
    localparam int N_FETCH    = 40;
    // Load and 40 fetches per lane need about 150 cycles.
    localparam int MAX_CYCLES = 2000;

    typedef struct packed {
        inst_num_e   num;
        logic [4:0]  rs2;
        logic [11:0] imm;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  run;
    logic                  load_en;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [31:0]           load_data;
    logic                  h0_valid;
    logic [ADDR_WIDTH+1:0] h0_pc;
    inst_num_e             h0_inst_num;
    logic [4:0]            h0_rs2;
    logic [11:0]           h0_imm;
    logic                  h1_valid;
    logic [ADDR_WIDTH+1:0] h1_pc;
    inst_num_e             h1_inst_num;
    logic [4:0]            h1_rs2;
    logic [11:0]           h1_imm;

    integer                seed = 32'he5683653;
    logic [31:0]           mem_copy [WORDS];
    logic [ADDR_WIDTH+1:0] exp_pc [2];
    int                    fetch_cnt [2];
    int                    cycle_cnt = 0;

    rv_frontend_top #(.ADDR_WIDTH(ADDR_WIDTH)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic expect_t decode_ref(input logic [31:0] w);
        expect_t    e;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        opcode = w[6:0];
        funct3 = w[14:12];
        funct7 = w[31:25];
        e.num  = inv;
        e.rs2  = '0;
        e.imm  = '0;
        if (opcode == 7'b0110011 && funct3 == 3'b000) begin
            if (funct7 == 7'h00) e.num = add;
            else if (funct7 == 7'h20) e.num = sub;
        end else if (opcode == 7'b0110011 && funct3 == 3'b101) begin
            if (funct7 == 7'h00) e.num = srl;
            else if (funct7 == 7'h20) e.num = sra;
        end else if (opcode == 7'b0010011 && funct3 == 3'b000) begin
            e.num = addi; // funct7 is part of the immediate.
        end else if (opcode == 7'b0010011 && funct3 == 3'b101) begin
            if (funct7 == 7'h00) e.num = srli;
            else if (funct7 == 7'h20) e.num = srai;
        end else if (w == 32'h0010_0073) begin
            e.num = ebreak;
        end
        if (e.num inside {add, sub, srl, sra}) begin
            e.rs2 = w[24:20];
        end
        if (e.num inside {addi, srli, srai}) begin
            e.imm = w[31:20];
        end
        return e;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] r;
        int          kind;
        logic [6:0]  f7;
        r    = $random(seed);
        kind = {$random(seed)} % 10;
        case (kind)
            0: random_word = {7'h00, r[24:15], 3'b000, r[11:7], 7'b0110011};
            1: random_word = {7'h20, r[24:15], 3'b000, r[11:7], 7'b0110011};
            2: random_word = {7'h00, r[24:15], 3'b101, r[11:7], 7'b0110011};
            3: random_word = {7'h20, r[24:15], 3'b101, r[11:7], 7'b0110011};
            4: random_word = {r[31:15], 3'b000, r[11:7], 7'b0010011};
            5: random_word = {7'h00, r[24:15], 3'b101, r[11:7], 7'b0010011};
            6: random_word = {7'h20, r[24:15], 3'b101, r[11:7], 7'b0010011};
            7: begin
                random_word = 32'h0010_0073;
                if (r[31]) begin
                    // Flip one bit outside the opcode.
                    random_word = random_word ^ (32'd1 << (7 + (r[30:26] % 25)));
                end
            end
            8: begin
                f7 = r[31:25];
                if (f7 == 7'h00 || f7 == 7'h20) f7 = f7 | 7'h01; // Bad funct7.
                random_word = {f7, r[24:15], r[12] ? 3'b101 : 3'b000, r[11:7], 7'b0110011};
            end
            default: random_word = r;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic check_lane(input int lane, input logic [ADDR_WIDTH+1:0] pc,
                              input inst_num_e num, input logic [4:0] rs2,
                              input logic [11:0] imm);
        expect_t e;
        e = decode_ref(mem_copy[exp_pc[lane][ADDR_WIDTH+1:2]]);
        check($sformatf("h%0d_pc", lane), pc, exp_pc[lane]);
        check($sformatf("h%0d_inst_num", lane), num, e.num);
        check($sformatf("h%0d_rs2", lane), rs2, e.rs2);
        check($sformatf("h%0d_imm", lane), imm, e.imm);
        exp_pc[lane]    = exp_pc[lane] + 'd4; // Wraps at 256.
        fetch_cnt[lane] = fetch_cnt[lane] + 1;
    endtask

    always @(negedge clk) begin : compare
        int skew;
        if (!run) begin
            check("h0_valid", h0_valid, 1'b0);
            check("h1_valid", h1_valid, 1'b0);
        end else begin
            if (h0_valid) check_lane(0, h0_pc, h0_inst_num, h0_rs2, h0_imm);
            if (h1_valid) check_lane(1, h1_pc, h1_inst_num, h1_rs2, h1_imm);
            skew = fetch_cnt[0] - fetch_cnt[1];
            check("valid count skew within one", (skew >= -1 && skew <= 1), 1'b1);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, fetches seen %0d and %0d.",
                     cycle_cnt, fetch_cnt[0], fetch_cnt[1]);
            $display("CHECKS FAILED");
            $fatal(1, "Simulation did not finish in time.");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main
        logic [31:0] w;
        rst_n        = 1'b0;
        run          = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        exp_pc[0]    = 'd0;
        exp_pc[1]    = 'd128;
        fetch_cnt[0] = 0;
        fetch_cnt[1] = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < WORDS; i++) begin
            w           = random_word();
            mem_copy[i] = w;
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= i[ADDR_WIDTH-1:0];
            load_data <= w;
        end
        @(posedge clk);
        load_en <= 1'b0;
        run     <= 1'b1;
        wait (fetch_cnt[0] >= N_FETCH && fetch_cnt[1] >= N_FETCH);
        @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/rv_pkg.sv
hdl/imem_bus_if.sv
hdl/inst_mem.sv
hdl/imem_arbiter.sv
hdl/fetch_unit.sv
hdl/idu_funct7.sv
hdl/idu.sv
hdl/rv_frontend_top.sv
testbench/tb_rv_frontend.sv

// File: Makefile
SRCS := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_rv_frontend: $(SRCS) verilog.f
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_rv_frontend -Mdir obj_dir

# Pass only when the pass message shows up in the output.
run: obj_dir/Vtb_rv_frontend
	@out="$$(./obj_dir/Vtb_rv_frontend 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
